// ==== hdl/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ====================
// Datapath sizing
// ====================
`define XLEN        32              // Data and address width
`define NUM_REGS    32              // Architectural registers, x0 included
`define RESET_PC    32'h0000_1000   // First PC after reset
`define QUEUE_DEPTH 4               // Decoded-record FIFO entries, power of two

// ====================
// RV32I major opcodes
// ====================
`define OPC_OP      7'b0110011      // Register-register ALU
`define OPC_OPIMM   7'b0010011      // Register-immediate ALU
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011      // Conditional branches
`define OPC_JAL     7'b1101111

`endif

// ==== hdl/corePkg.sv ====
`include "core_consts.svh"

package corePkg;

    // ====================
    // Instruction classes
    // ====================
    typedef enum logic [2:0] {
        clsAlu    = 3'd0,   // OP and OP-IMM
        clsLui    = 3'd1,
        clsBranch = 3'd2,
        clsJal    = 3'd3
    } instrClassT;

    // ALU operation select
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSlt  = 4'd5,
        aluSltu = 4'd6,
        aluSll  = 4'd7,
        aluSrl  = 4'd8,
        aluSra  = 4'd9
    } aluOpT;

    // Encoded as the branch funct3, so decode is a plain cast
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCondT;

    // ====================
    // Decoded record, the FIFO payload
    // ====================
    typedef struct packed {
        instrClassT        instrClass;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [`XLEN-1:0]  immediate;   // Already sign-extended and shifted
        logic              useImm;      // Operand B from immediate, not rs2
        aluOpT             aluOp;
        branchCondT        branchCond;
        logic              writesRd;    // Low for x0 and for branches
    } decodedInstrT;

endpackage

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module instrDecoder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`XLEN-1:0]     instr,
    input  logic                 instrValid,
    output logic                 instrReady,
    output corePkg::decodedInstrT decoded,
    output logic                 decValid,
    input  logic                 decReady,
    output logic [`XLEN-1:0]     droppedCount
);

    // ====================
    // Field extraction
    // ====================
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [`XLEN-1:0] immI, immB, immU, immJ;
    corePkg::aluOpT aluSel;
    corePkg::decodedInstrT rec;
    logic supported;
    logic accept;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Immediate formats
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 to ALU op; funct7[5] picks SUB (OP only) and SRA
    always_comb begin
        case (funct3)
            3'b000:  aluSel = (opcode == `OPC_OP && funct7[5]) ? corePkg::aluSub
                                                                : corePkg::aluAdd;
            3'b001:  aluSel = corePkg::aluSll;
            3'b010:  aluSel = corePkg::aluSlt;
            3'b011:  aluSel = corePkg::aluSltu;
            3'b100:  aluSel = corePkg::aluXor;
            3'b101:  aluSel = funct7[5] ? corePkg::aluSra : corePkg::aluSrl;
            3'b110:  aluSel = corePkg::aluOr;
            default: aluSel = corePkg::aluAnd;
        endcase
    end

    // ====================
    // Record build and legality
    // ====================
    always_comb begin
        rec            = '0;
        supported      = 1'b0;
        rec.rd         = instr[11:7];
        rec.rs1        = instr[19:15];
        rec.rs2        = instr[24:20];
        rec.aluOp      = aluSel;
        rec.branchCond = corePkg::branchCondT'(funct3);
        case (opcode)
            `OPC_OP: begin
                rec.instrClass = corePkg::clsAlu;
                supported = (funct7 == 7'h00) ||
                            (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `OPC_OPIMM: begin
                rec.instrClass = corePkg::clsAlu;
                rec.immediate  = immI;
                rec.useImm     = 1'b1;
                rec.rs2        = 5'd0;            // Field is immediate bits
                if (funct3 == 3'b001)
                    supported = (funct7 == 7'h00);  // SLLI
                else if (funct3 == 3'b101)
                    supported = (funct7 == 7'h00) || (funct7 == 7'h20);
                else
                    supported = 1'b1;
            end
            `OPC_LUI: begin
                rec.instrClass = corePkg::clsLui;
                rec.immediate  = immU;
                rec.rs1        = 5'd0;
                rec.rs2        = 5'd0;
                supported      = 1'b1;
            end
            `OPC_BRANCH: begin
                rec.instrClass = corePkg::clsBranch;
                rec.immediate  = immB;
                rec.rd         = 5'd0;
                supported      = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            `OPC_JAL: begin
                rec.instrClass = corePkg::clsJal;
                rec.immediate  = immJ;
                rec.rs1        = 5'd0;
                rec.rs2        = 5'd0;
                supported      = 1'b1;
            end
            default: supported = 1'b0;            // Unknown opcode
        endcase
        rec.writesRd = (rec.rd != 5'd0) && (rec.instrClass != corePkg::clsBranch);
    end

    // ====================
    // One-entry output register
    // ====================
    assign instrReady = !decValid || decReady;   // Empty or draining this cycle
    assign accept     = instrValid && instrReady;

    always_ff @(posedge clk) begin
        if (!reset) begin
            decValid     <= 1'b0;
            droppedCount <= '0;
        end else if (accept) begin
            decValid <= supported;                   // Dropped word leaves register empty
            if (!supported)
                droppedCount <= droppedCount + 1'b1;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && supported)
            decoded <= rec;                          // Payload, no reset
    end

    // Held record must not change under back-pressure
    assert property (@(posedge clk) disable iff (!reset)
        decValid && !decReady |=> decValid && $stable(decoded));

endmodule

// ==== hdl/decodedQueue.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module decodedQueue #(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  corePkg::decodedInstrT inData,
    input  logic                  inValid,
    output logic                  inReady,
    output corePkg::decodedInstrT outData,
    output logic                  outValid,
    input  logic                  outReady
);

    localparam int PtrW = $clog2(DEPTH);
    localparam int CntW = $clog2(DEPTH + 1);

    // ====================
    // Storage and pointers
    // ====================
    corePkg::decodedInstrT mem [DEPTH];
    logic [PtrW-1:0] wrPtr, rdPtr;   // Wrap naturally, DEPTH is a power of two
    logic [CntW-1:0] count;
    logic full;
    logic wrEn, rdEn;

    assign full     = (count == CntW'(DEPTH));
    assign outValid = (count != '0);
    assign outData  = mem[rdPtr];            // Head of queue
    assign inReady  = !full || outReady;     // Full queue still takes a write on a read
    assign wrEn     = inValid && inReady;
    assign rdEn     = outValid && outReady;

    always_ff @(posedge clk) begin
        if (wrEn)
            mem[wrPtr] <= inData;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn)
                wrPtr <= wrPtr + 1'b1;
            if (rdEn)
                rdPtr <= rdPtr + 1'b1;
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
        end
    end

    // Occupancy bound
    assert property (@(posedge clk) disable iff (!reset) count <= CntW'(DEPTH));

    // Read side only moves off a non-empty queue
    assert property (@(posedge clk) disable iff (!reset)
        (rdPtr != $past(rdPtr)) |-> ($past(count) != '0));

endmodule

// ==== hdl/execUnit.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module execUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  corePkg::decodedInstrT queued,
    input  logic                  queueValid,
    output logic                  queueReady,
    output logic [`XLEN-1:0]      resultPc,
    output logic [`XLEN-1:0]      resultNextPc,
    output logic [4:0]            resultRd,
    output logic [`XLEN-1:0]      resultValue,
    output logic                  resultWrite,
    output logic                  resultTaken,
    output logic                  resultValid,
    input  logic                  resultReady,
    output logic [`XLEN-1:0]      instrCount,
    output logic [`XLEN-1:0]      branchCount
);

    // ====================
    // Architectural state
    // ====================
    logic [`XLEN-1:0] regFile [`NUM_REGS];
    logic [`XLEN-1:0] pc;

    logic [`XLEN-1:0] rs1Data, rs2Data;
    logic [`XLEN-1:0] opA, opB, diff, aluResult;
    logic [`XLEN-1:0] value, nextPc;
    logic ltSigned, ltUnsigned;
    logic condTrue, taken;
    logic accept;
    logic isBranch;

    // Combinational read; x0 stays zero because it is never written
    assign rs1Data = regFile[queued.rs1];
    assign rs2Data = regFile[queued.rs2];

    // ====================
    // ALU
    // ====================
    assign opA        = rs1Data;
    assign opB        = queued.useImm ? queued.immediate : rs2Data;
    assign diff       = opA - opB;
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (queued.aluOp)
            corePkg::aluAdd:  aluResult = opA + opB;
            corePkg::aluSub:  aluResult = diff;
            corePkg::aluAnd:  aluResult = opA & opB;
            corePkg::aluOr:   aluResult = opA | opB;
            corePkg::aluXor:  aluResult = opA ^ opB;
            corePkg::aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, ltSigned};
            corePkg::aluSltu: aluResult = {{(`XLEN-1){1'b0}}, ltUnsigned};
            corePkg::aluSll:  aluResult = opA << opB[4:0];    // Shamt is low 5 bits
            corePkg::aluSrl:  aluResult = opA >> opB[4:0];
            corePkg::aluSra:  aluResult = $signed(opA) >>> opB[4:0];
            default:          aluResult = opA + opB;
        endcase
    end

    // Branch outcome from compare and difference
    always_comb begin
        case (queued.branchCond)
            corePkg::brEq:  condTrue = (diff == '0);
            corePkg::brNe:  condTrue = (diff != '0);
            corePkg::brLt:  condTrue = ltSigned;
            corePkg::brGe:  condTrue = !ltSigned;
            corePkg::brLtu: condTrue = ltUnsigned;
            default:        condTrue = !ltUnsigned;           // GEU
        endcase
    end

    assign isBranch = (queued.instrClass == corePkg::clsBranch);
    assign taken    = (isBranch && condTrue) || (queued.instrClass == corePkg::clsJal);
    assign nextPc   = taken ? pc + queued.immediate : pc + `XLEN'd4;

    // Writeback value per class
    always_comb begin
        case (queued.instrClass)
            corePkg::clsLui: value = queued.immediate;
            corePkg::clsJal: value = pc + `XLEN'd4;            // Link address
            corePkg::clsAlu: value = aluResult;
            default:         value = '0;                       // Branch writes nothing
        endcase
    end

    // ====================
    // Accept, writeback, PC and counters
    // ====================
    assign queueReady = !resultValid || resultReady;   // Result slot free or draining
    assign accept     = queueValid && queueReady;

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regFile[i] <= '0;
            pc          <= `RESET_PC;
            resultValid <= 1'b0;
            instrCount  <= '0;
            branchCount <= '0;
        end else if (accept) begin
            if (queued.writesRd && queued.rd != 5'd0)
                regFile[queued.rd] <= value;   // Visible to the next record
            pc          <= nextPc;
            resultValid <= 1'b1;
            instrCount  <= instrCount + 1'b1;
            if (isBranch)
                branchCount <= branchCount + 1'b1;
        end else if (resultReady) begin
            resultValid <= 1'b0;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (accept) begin
            resultPc     <= pc;
            resultNextPc <= nextPc;
            resultRd     <= queued.rd;
            resultValue  <= value;
            resultWrite  <= queued.writesRd;
            resultTaken  <= taken;
        end
    end

    // Stalled result holds until taken
    assert property (@(posedge clk) disable iff (!reset)
        resultValid && !resultReady |=> resultValid &&
        $stable({resultPc, resultNextPc, resultRd, resultValue, resultWrite, resultTaken}));

endmodule

// ==== hdl/coreTop.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module coreTop (
    input  logic              clk,
    input  logic              reset,
    input  logic [`XLEN-1:0]  instr,
    input  logic              instrValid,
    output logic              instrReady,
    output logic [`XLEN-1:0]  resultPc,
    output logic [`XLEN-1:0]  resultNextPc,
    output logic [4:0]        resultRd,
    output logic [`XLEN-1:0]  resultValue,
    output logic              resultWrite,
    output logic              resultTaken,
    output logic              resultValid,
    input  logic              resultReady,
    output logic [`XLEN-1:0]  instrCount,
    output logic [`XLEN-1:0]  branchCount,
    output logic [`XLEN-1:0]  droppedCount
);

    // ====================
    // Stage links
    // ====================
    corePkg::decodedInstrT decoded, queued;
    logic decValid, decReady;
    logic queueValid, queueReady;

    // Producer
    instrDecoder decoder_i (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instrValid   (instrValid),
        .instrReady   (instrReady),
        .decoded      (decoded),
        .decValid     (decValid),
        .decReady     (decReady),
        .droppedCount (droppedCount)
    );

    // Buffer
    decodedQueue #(.DEPTH(`QUEUE_DEPTH)) queue_i (
        .clk      (clk),
        .reset    (reset),
        .inData   (decoded),
        .inValid  (decValid),
        .inReady  (decReady),
        .outData  (queued),
        .outValid (queueValid),
        .outReady (queueReady)
    );

    // Consumer
    execUnit exec_i (
        .clk          (clk),
        .reset        (reset),
        .queued       (queued),
        .queueValid   (queueValid),
        .queueReady   (queueReady),
        .resultPc     (resultPc),
        .resultNextPc (resultNextPc),
        .resultRd     (resultRd),
        .resultValue  (resultValue),
        .resultWrite  (resultWrite),
        .resultTaken  (resultTaken),
        .resultValid  (resultValid),
        .resultReady  (resultReady),
        .instrCount   (instrCount),
        .branchCount  (branchCount)
    );

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ns

module clockGen #(
    parameter int HalfPeriod  = 4,    // 8 ns clock
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Active low, released just after an edge
    initial begin
        reset = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1 reset = 1'b1;
    end

endmodule

// ==== dv/coreTopTb.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module coreTopTb;

    logic clk, reset;
    logic [`XLEN-1:0] instr;
    logic instrValid, instrReady;
    logic [`XLEN-1:0] resultPc, resultNextPc, resultValue;
    logic [4:0] resultRd;
    logic resultWrite, resultTaken, resultValid, resultReady;
    logic [`XLEN-1:0] instrCount, branchCount, droppedCount;

    // One program step and what the core must report for it
    typedef struct {
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] nextPc;
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
        logic             write;
        logic             taken;
        logic             dropped;   // No result expected
    } stepT;

    stepT steps[$];

    clockGen clkGen_i (.clk(clk), .reset(reset));

    coreTop coreTop_i (
        .clk(clk), .reset(reset),
        .instr(instr), .instrValid(instrValid), .instrReady(instrReady),
        .resultPc(resultPc), .resultNextPc(resultNextPc), .resultRd(resultRd),
        .resultValue(resultValue), .resultWrite(resultWrite), .resultTaken(resultTaken),
        .resultValid(resultValid), .resultReady(resultReady),
        .instrCount(instrCount), .branchCount(branchCount), .droppedCount(droppedCount)
    );

    // ====================
    // Encoders and LFSR
    // ====================
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] iType(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OPC_OPIMM};
    endfunction

    function automatic logic [31:0] uType(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `OPC_LUI};
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // ====================
    // Checks
    // ====================
    task automatic failRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic wordCompare(input string name, input logic [`XLEN-1:0] got, exp);
        if (got !== exp)
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic indexCompare(input string name, input logic [4:0] got, exp);
        if (got !== exp)
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic flagCompare(input string name, input logic got, exp);
        if (got !== exp)
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic counterCompare(input string name, input logic [`XLEN-1:0] got, exp);
        if (got !== exp)
            failRun($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // ====================
    // Program table
    // ====================
    task automatic addRow(input logic [31:0] word, pc, nextPc, input logic [4:0] rd,
                          input logic [31:0] value, input logic write, taken);
        steps.push_back('{word, pc, nextPc, rd, value, write, taken, 1'b0});
    endtask

    task automatic dropRow(input logic [31:0] word);
        steps.push_back('{word, '0, '0, '0, '0, 1'b0, 1'b0, 1'b1});
    endtask

    task automatic loadSteps();
        addRow(iType(3'b000, 5'd1, 5'd0, 12'd5), 32'h1000, 32'h1004, 5'd1, 32'd5, 1, 0);
        addRow(iType(3'b000, 5'd2, 5'd0, 12'hffd), 32'h1004, 32'h1008, 5'd2, 32'hffff_fffd, 1, 0);
        addRow(rType(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 32'h1008, 32'h100c, 5'd3, 32'd2, 1, 0);
        addRow(rType(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), 32'h100c, 32'h1010, 5'd4, 32'd8, 1, 0);
        addRow(uType(5'd5, 20'h80000), 32'h1010, 32'h1014, 5'd5, 32'h8000_0000, 1, 0);
        addRow(rType(7'h20, 3'b101, 5'd6, 5'd5, 5'd1), 32'h1014, 32'h1018, 5'd6, 32'hfc00_0000, 1, 0);
        addRow(rType(7'h00, 3'b101, 5'd7, 5'd5, 5'd1), 32'h1018, 32'h101c, 5'd7, 32'h0400_0000, 1, 0);
        addRow(rType(7'h00, 3'b001, 5'd8, 5'd1, 5'd1), 32'h101c, 32'h1020, 5'd8, 32'h0000_00a0, 1, 0);
        addRow(rType(7'h00, 3'b010, 5'd9, 5'd2, 5'd1), 32'h1020, 32'h1024, 5'd9, 32'd1, 1, 0);
        addRow(rType(7'h00, 3'b011, 5'd10, 5'd2, 5'd1), 32'h1024, 32'h1028, 5'd10, 32'd0, 1, 0);
        addRow(rType(7'h00, 3'b100, 5'd11, 5'd1, 5'd2), 32'h1028, 32'h102c, 5'd11, 32'hffff_fff8, 1, 0);
        addRow(rType(7'h00, 3'b110, 5'd12, 5'd1, 5'd4), 32'h102c, 32'h1030, 5'd12, 32'h0000_000d, 1, 0);
        addRow(rType(7'h00, 3'b111, 5'd13, 5'd2, 5'd4), 32'h1030, 32'h1034, 5'd13, 32'd8, 1, 0);
        addRow(iType(3'b000, 5'd0, 5'd1, 12'd7), 32'h1034, 32'h1038, 5'd0, 32'd0, 0, 0);  // x0
        addRow(rType(7'h00, 3'b000, 5'd14, 5'd0, 5'd1), 32'h1038, 32'h103c, 5'd14, 32'd5, 1, 0);
        addRow(iType(3'b010, 5'd15, 5'd2, 12'hffe), 32'h103c, 32'h1040, 5'd15, 32'd1, 1, 0);
        addRow(iType(3'b011, 5'd16, 5'd1, 12'hfff), 32'h1040, 32'h1044, 5'd16, 32'd1, 1, 0);
        addRow(iType(3'b111, 5'd17, 5'd2, 12'h0f0), 32'h1044, 32'h1048, 5'd17, 32'h0000_00f0, 1, 0);
        addRow(iType(3'b110, 5'd18, 5'd1, 12'h100), 32'h1048, 32'h104c, 5'd18, 32'h0000_0105, 1, 0);
        addRow(iType(3'b100, 5'd19, 5'd1, 12'hfff), 32'h104c, 32'h1050, 5'd19, 32'hffff_fffa, 1, 0);
        addRow(iType(3'b001, 5'd20, 5'd1, 12'h003), 32'h1050, 32'h1054, 5'd20, 32'h0000_0028, 1, 0);
        addRow(iType(3'b101, 5'd21, 5'd5, 12'h004), 32'h1054, 32'h1058, 5'd21, 32'h0800_0000, 1, 0);
        addRow(iType(3'b101, 5'd22, 5'd5, 12'h404), 32'h1058, 32'h105c, 5'd22, 32'hf800_0000, 1, 0);
        dropRow(32'h0000_0000);                                        // Unknown opcode
        addRow(bType(3'b000, 5'd1, 5'd1, 13'd8), 32'h105c, 32'h1064, 5'd0, 32'd0, 0, 1);
        addRow(bType(3'b001, 5'd1, 5'd1, 13'd8), 32'h1064, 32'h1068, 5'd0, 32'd0, 0, 0);
        addRow(bType(3'b100, 5'd2, 5'd1, 13'd12), 32'h1068, 32'h1074, 5'd0, 32'd0, 0, 1);
        addRow(bType(3'b101, 5'd2, 5'd1, 13'd8), 32'h1074, 32'h1078, 5'd0, 32'd0, 0, 0);
        addRow(bType(3'b110, 5'd2, 5'd1, 13'd8), 32'h1078, 32'h107c, 5'd0, 32'd0, 0, 0);
        addRow(bType(3'b111, 5'd2, 5'd1, 13'h1ff0), 32'h107c, 32'h106c, 5'd0, 32'd0, 0, 1);
        dropRow(rType(7'h01, 3'b000, 5'd26, 5'd1, 5'd2));            // MUL, illegal funct7
        addRow(jType(5'd23, 21'd20), 32'h106c, 32'h1080, 5'd23, 32'h0000_1070, 1, 1);
        addRow(rType(7'h00, 3'b000, 5'd24, 5'd23, 5'd1), 32'h1080, 32'h1084, 5'd24, 32'h1075, 1, 0);
        addRow(jType(5'd0, 21'h1ffff8), 32'h1084, 32'h107c, 5'd0, 32'd0, 0, 1);
        addRow(iType(3'b000, 5'd25, 5'd0, 12'd1), 32'h107c, 32'h1080, 5'd25, 32'd1, 1, 0);
        addRow(bType(3'b001, 5'd25, 5'd0, 13'd16), 32'h1080, 32'h1090, 5'd0, 32'd0, 0, 1);
        addRow(uType(5'd0, 20'h12345), 32'h1090, 32'h1094, 5'd0, 32'd0, 0, 0);
        addRow(bType(3'b000, 5'd1, 5'd2, 13'd8), 32'h1094, 32'h1098, 5'd0, 32'd0, 0, 0);
        addRow(bType(3'b100, 5'd1, 5'd2, 13'd8), 32'h1098, 32'h109c, 5'd0, 32'd0, 0, 0);
        addRow(bType(3'b101, 5'd1, 5'd2, 13'd8), 32'h109c, 32'h10a4, 5'd0, 32'd0, 0, 1);
        addRow(bType(3'b110, 5'd1, 5'd2, 13'd8), 32'h10a4, 32'h10ac, 5'd0, 32'd0, 0, 1);
        addRow(bType(3'b111, 5'd1, 5'd2, 13'd8), 32'h10ac, 32'h10b0, 5'd0, 32'd0, 0, 0);
        addRow(rType(7'h00, 3'b000, 5'd27, 5'd26, 5'd1), 32'h10b0, 32'h10b4, 5'd27, 32'd5, 1, 0);
    endtask

    // ====================
    // Stimulus and response
    // ====================
    task automatic driveWords();
        logic [31:0] state;
        int gap;
        logic done;
        state = 32'h2863_9bb8;
        @(posedge clk);
        #1;                                           // Drive point after the edge
        foreach (steps[i]) begin
            state = lfsrStep(state);
            gap   = state[0];
            state = lfsrStep(state);
            gap   = gap + 2 * state[0];               // 0 to 3 idle cycles
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            instr      = steps[i].word;
            instrValid = 1'b1;
            do begin
                @(negedge clk);
                done = instrReady;                    // Transfer at the next edge
                @(posedge clk);
                #1;
            end while (!done);
            instrValid = 1'b0;
        end
    endtask

    task automatic toggleReady();
        logic [31:0] state;
        state = 32'h2863_9bb8;
        repeat (16) state = lfsrStep(state);          // Offset from the driver's stream
        forever begin
            @(posedge clk);
            #1;
            state       = lfsrStep(state);
            resultReady = state[0];
        end
    endtask

    task automatic resultChecker();
        int idx;
        idx = 0;
        while (idx < steps.size()) begin
            if (steps[idx].dropped) begin
                idx++;                                // Nothing comes back for it
            end else begin
                @(negedge clk);
                if (resultValid && resultReady) begin
                    wordCompare("resultPc", resultPc, steps[idx].pc);
                    wordCompare("resultNextPc", resultNextPc, steps[idx].nextPc);
                    flagCompare("resultWrite", resultWrite, steps[idx].write);
                    flagCompare("resultTaken", resultTaken, steps[idx].taken);
                    indexCompare("resultRd", resultRd, steps[idx].rd);
                    if (steps[idx].write)
                        wordCompare("resultValue", resultValue, steps[idx].value);
                    idx++;
                end
            end
        end
    endtask

    task automatic watchdog();
        repeat (steps.size() * 40) @(posedge clk);
        failRun("Timeout: results stopped arriving before the end of the table");
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int expInstr;
        int expBranch;
        int expDrop;
        instr       = '0;
        instrValid  = 1'b0;
        resultReady = 1'b0;
        expInstr    = 0;
        expBranch   = 0;
        expDrop     = 0;
        loadSteps();
        foreach (steps[i]) begin
            if (steps[i].dropped)
                expDrop++;
            else begin
                expInstr++;
                if (steps[i].word[6:0] == `OPC_BRANCH)
                    expBranch++;
            end
        end
        fork
            watchdog();
        join_none
        wait (reset === 1'b1);
        @(negedge clk);
        counterCompare("instrCount", instrCount, '0);     // Fresh out of reset
        counterCompare("branchCount", branchCount, '0);
        counterCompare("droppedCount", droppedCount, '0);
        flagCompare("instrReady", instrReady, 1'b1);
        flagCompare("resultValid", resultValid, 1'b0);
        fork
            driveWords();
            toggleReady();
        join_none
        resultChecker();
        counterCompare("instrCount", instrCount, expInstr);
        counterCompare("branchCount", branchCount, expBranch);
        counterCompare("droppedCount", droppedCount, expDrop);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== coreTop.f ====
+incdir+hdl
hdl/corePkg.sv
hdl/instrDecoder.sv
hdl/decodedQueue.sv
hdl/execUnit.sv
hdl/coreTop.sv
dv/clockGen.sv
dv/coreTopTb.sv

// ==== Makefile ====
SIM     ?= verilator
TOP     ?= coreTopTb
FLIST   ?= coreTop.f
OBJDIR  ?= obj_dir
LOG     ?= sim.log
VFLAGS  ?= --binary --timing --assert -Wno-fatal

SRCS    := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard hdl/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "No pass report in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
